//--- sim.f
verilog/mem_geom_pkg.sv
verilog/mem_req_pkg.sv
verilog/mem_req_decode.sv
verilog/mem_word_array.sv
verilog/mem_fill_pipe.sv
verilog/mem_top.sv
sim/mem_tb.sv

//--- Bender.yml
package:
  name: mem_backing

sources:
  # Packages first, then the design from the leaves up to the top level.
  - files:
      - verilog/mem_geom_pkg.sv
      - verilog/mem_req_pkg.sv
      - verilog/mem_req_decode.sv
      - verilog/mem_word_array.sv
      - verilog/mem_fill_pipe.sv
      - verilog/mem_top.sv

  # Testbench, only for simulation.
  - target: simulation
    files:
      - sim/mem_tb.sv

//--- sim/mem_tb.sv
`timescale 1ns/1ns

module mem_tb;

    localparam int spaces      = 128;   // Words in storage.
    localparam int dtt         = 5;     // Load latency in cycles.
    localparam int clk_period  = 40;
    localparam int wpl         = mem_geom_pkg::words_per_line;
    localparam int ww          = mem_geom_pkg::word_width;

    localparam int reset_cycles  = 5;
    localparam int quiet_cycles  = 4 * dtt;
    localparam int line_checks   = 8;
    localparam int b2b_loads     = 12;
    localparam int raw_rounds    = 6;
    localparam int alias_rounds  = 6;
    localparam int random_ops    = 300;
    localparam int drain_cycles  = dtt + 2;
    localparam int margin_cycles = 50;

    // Upper bound on cycles spent issuing requests and draining them.
    localparam int request_budget = reset_cycles + quiet_cycles + spaces
                                  + line_checks * (1 + drain_cycles + 1)
                                  + b2b_loads + raw_rounds * 3 + alias_rounds * 4
                                  + random_ops + 6 * (drain_cycles + 1);
    localparam int watchdog_ns = (request_budget + dtt + margin_cycles) * clk_period;

    // One load waiting for its response.
    typedef struct packed {
        mem_geom_pkg::line_t line;     // Line expected back.
        logic [31:0]         cycle;    // Cycle count when the load was driven.
    } expect_t;

    logic                clk;
    logic                rst_n;
    logic                req;
    logic                store;
    mem_geom_pkg::addr_t address;
    mem_geom_pkg::word_t evict_data;
    mem_geom_pkg::line_t fill_data;
    logic                response_valid;

    logic [31:0]         cycle_cnt;
    integer              seed;
    int                  error_count;
    int                  test_errors;
    int                  tests_passed;
    int                  tests_failed;

    mem_geom_pkg::word_t model [spaces];    // Reference copy of storage.
    expect_t             expect_q [$];      // Loads in flight, oldest first.

    mem_top #(
        .SPACES             (spaces),
        .DATA_TRANSFER_TIME (dtt)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .store          (store),
        .address        (address),
        .evict_data     (evict_data),
        .fill_data      (fill_data),
        .response_valid (response_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;    // Number of rising edges so far.
    end

    // Responses come out in order, so only the queue head can match.
    always @(negedge clk) begin : check_responses
        expect_t head;
        if (response_valid) begin
            resp_expected: assert (expect_q.size() != 0) else begin
                report_value("response_valid", 0, 1);
            end
            if (expect_q.size() != 0) begin
                head = expect_q.pop_front();
                line_match: assert (fill_data === head.line) else begin
                    report_value("fill_data", head.line, fill_data);
                end
                latency_match: assert (cycle_cnt == head.cycle + dtt) else begin
                    report_value("response_valid cycle", head.cycle + dtt, cycle_cnt);
                end
            end
        end else if (expect_q.size() != 0) begin
            // A load past its due cycle is dropped so later ones still line up.
            resp_on_time: assert (cycle_cnt < expect_q[0].cycle + dtt) else begin
                report_value("response_valid", 1, 0);
                head = expect_q.pop_front();
            end
        end
    end

    task automatic report_value(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    // Pattern that differs for every word address.
    function automatic mem_geom_pkg::word_t pattern_word(input int unsigned a);
        return (a * 32'h9e37_79b1) ^ ~a;
    endfunction

    // Expected line from the model, word 0 lowest.
    function automatic mem_geom_pkg::line_t model_line(input mem_geom_pkg::addr_t a);
        mem_geom_pkg::line_t line;
        int                  base;
        base = (a % spaces) / wpl * wpl;
        for (int k = 0; k < wpl; k++) begin
            line[k*ww +: ww] = model[base + k];
        end
        return line;
    endfunction

    task automatic idle_cycle();
        @(negedge clk);
        req   = 1'b0;
        store = 1'b0;
    endtask

    task automatic do_store(input mem_geom_pkg::addr_t a, input mem_geom_pkg::word_t d);
        @(negedge clk);
        req        = 1'b1;
        store      = 1'b1;
        address    = a;
        evict_data = d;
        model[a % spaces] = d;    // Visible to any later load.
    endtask

    task automatic do_load(input mem_geom_pkg::addr_t a);
        expect_t e;
        @(negedge clk);
        req     = 1'b1;
        store   = 1'b0;
        address = a;
        e.line  = model_line(a);
        e.cycle = cycle_cnt;
        expect_q.push_back(e);
    endtask

    // Idle until every outstanding load has returned.
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (expect_q.size() != 0 && waited < drain_cycles) begin
            idle_cycle();
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("Responses missing at %0t ns: %0d loads never returned",
                     $time, expect_q.size());
            error_count++;
            expect_q.delete();
        end
    endtask

    task automatic start_test();
        test_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - test_errors);
            tests_failed++;
        end
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("Watchdog expired at %0t ns: responses stopped before the tests finished",
                 $time);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        mem_geom_pkg::addr_t a;
        mem_geom_pkg::addr_t alias_a;
        mem_geom_pkg::word_t d;
        int                  line_sel;
        int                  r;

        rst_n        = 1'b0;
        req          = 1'b0;
        store        = 1'b0;
        address      = '0;
        evict_data   = '0;
        cycle_cnt    = '0;
        seed         = 32'hb7e0;
        error_count  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;

        // Reset quietness; the checker flags any response with no load queued.
        start_test();
        repeat (reset_cycles) begin
            @(posedge clk);
            @(negedge clk);
            reset_low: assert (response_valid === 1'b0) else begin
                report_value("response_valid", 0, response_valid);
            end
        end
        rst_n = 1'b1;
        repeat (quiet_cycles) idle_cycle();
        finish_test("reset_quiet");

        // Fill every word, then read back a handful of lines one at a time.
        start_test();
        for (int i = 0; i < spaces; i++) begin
            do_store(i, pattern_word(i));
        end
        idle_cycle();
        for (int i = 0; i < line_checks; i++) begin
            line_sel = (i * 5 + 3) % (spaces / wpl);
            do_load(line_sel * wpl + (i % wpl));
            wait_for_drain();
        end
        finish_test("store_then_load");

        // One load per cycle to different lines.
        start_test();
        for (int i = 0; i < b2b_loads; i++) begin
            do_load(((i * 7) % (spaces / wpl)) * wpl);
        end
        wait_for_drain();
        finish_test("back_to_back");

        // Old line, new word, then the same line on the very next cycle.
        start_test();
        for (int i = 0; i < raw_rounds; i++) begin
            a = (($random(seed) & 32'h7fff_ffff) % spaces);
            d = $random(seed);
            do_load(a);
            do_store(a, d);
            do_load(a);
        end
        wait_for_drain();
        finish_test("read_after_write");

        // Upper address bits are ignored in both directions.
        start_test();
        for (int i = 0; i < alias_rounds; i++) begin
            a       = $random(seed) & (spaces - 1);
            alias_a = ($random(seed) & ~(spaces - 1)) | a;
            if (alias_a == a) begin
                alias_a = alias_a | spaces;
            end
            do_store(alias_a, $random(seed));
            do_load(a);
            do_store(a, $random(seed));
            do_load(alias_a);
        end
        wait_for_drain();
        finish_test("address_alias");

        // Mixed traffic on full 32-bit addresses.
        start_test();
        for (int i = 0; i < random_ops; i++) begin
            r = $random(seed);
            a = $random(seed);
            case (r & 3)
                0:       idle_cycle();
                1:       do_store(a, $random(seed));
                default: do_load(a);
            endcase
        end
        wait_for_drain();
        finish_test("random_mix");

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/mem_top.sv
`timescale 1ns/1ns

module mem_top #(
    parameter int SPACES             = 128,   // Words in storage.
    parameter int DATA_TRANSFER_TIME = 5      // Load latency in cycles.
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  logic                 store,
    input  mem_geom_pkg::addr_t  address,
    input  mem_geom_pkg::word_t  evict_data,
    output mem_geom_pkg::line_t  fill_data,
    output logic                 response_valid
);

    mem_req_pkg::mem_req_t   dec_req;       // Decode to array.
    mem_req_pkg::fill_beat_t exec_beat;     // Array to fill pipe.
    mem_req_pkg::fill_beat_t result_beat;   // Fill pipe output.

    // Request register and classification.
    mem_req_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .store      (store),
        .address    (address),
        .evict_data (evict_data),
        .dec_req    (dec_req)
    );

    mem_word_array #(
        .SPACES (SPACES)
    ) u_array (
        .clk       (clk),
        .dec_req   (dec_req),
        .exec_beat (exec_beat)
    );

    // Slow return path for load lines.
    mem_fill_pipe #(
        .DATA_TRANSFER_TIME (DATA_TRANSFER_TIME)
    ) u_fill (
        .clk         (clk),
        .rst_n       (rst_n),
        .exec_beat   (exec_beat),
        .result_beat (result_beat)
    );

    assign response_valid = result_beat.valid;
    assign fill_data      = result_beat.line;    // Meaningful only with response_valid.

endmodule

//--- verilog/mem_fill_pipe.sv
`timescale 1ns/1ns

module mem_fill_pipe #(
    parameter int DATA_TRANSFER_TIME = 5
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_req_pkg::fill_beat_t  exec_beat,
    output mem_req_pkg::fill_beat_t  result_beat
);

    // The decode register takes one cycle of the transfer time.
    localparam int stages = DATA_TRANSFER_TIME - 1;

    logic [stages-1:0]   valid_q;             // One flag per load in flight.
    mem_geom_pkg::line_t line_q [stages];     // Line data per stage.

    // Valid chain is control state and is cleared.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= exec_beat.valid;
            for (int i = 1; i < stages; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Data moves every cycle; only the valid flag matters.
    always_ff @(posedge clk) begin
        line_q[0] <= exec_beat.line;
        for (int i = 1; i < stages; i++) begin
            line_q[i] <= line_q[i-1];
        end
    end

    // Last stage is the response.
    always_comb begin
        result_beat.valid = valid_q[stages-1];
        result_beat.line  = line_q[stages-1];
    end

endmodule

//--- verilog/mem_word_array.sv
`timescale 1ns/1ns

module mem_word_array #(
    parameter int SPACES = 128
) (
    input  logic                     clk,
    input  mem_req_pkg::mem_req_t    dec_req,
    output mem_req_pkg::fill_beat_t  exec_beat
);

    localparam int idx_width  = $clog2(SPACES);                       // Word index bits.
    localparam int wil_width  = $clog2(mem_geom_pkg::words_per_line); // Word in line bits.
    localparam int lines      = SPACES / mem_geom_pkg::words_per_line;
    localparam int line_width = idx_width - wil_width;                // Line index bits.

    logic [idx_width-1:0]  word_idx;    // Target word of a store.
    logic [line_width-1:0] line_idx;    // Line picked for a load.
    logic                  is_store;
    logic                  is_load;
    logic [SPACES-1:0]     wr_en;       // One-hot write enable.

    mem_geom_pkg::word_t words_q [SPACES];    // Word storage, no reset.
    mem_geom_pkg::line_t lines_out [lines];   // Words grouped into lines.

    // Upper address bits alias, so only the low index is used.
    assign word_idx = dec_req.addr[idx_width-1:0];
    assign line_idx = dec_req.addr[idx_width-1:wil_width];

    assign is_store = (dec_req.kind == mem_req_pkg::store);
    assign is_load  = (dec_req.kind == mem_req_pkg::load);

    // Decode the word index into a single write strobe.
    always_comb begin
        wr_en = '0;
        if (is_store) begin
            wr_en[word_idx] = 1'b1;
        end
    end

    genvar w;
    generate
        for (w = 0; w < SPACES; w++) begin : g_word
            always_ff @(posedge clk) begin
                if (wr_en[w]) begin
                    words_q[w] <= dec_req.data;
                end
            end
        end
    endgenerate

    // Word 0 of each line goes to the lowest bits.
    genvar l;
    genvar k;
    generate
        for (l = 0; l < lines; l++) begin : g_line
            for (k = 0; k < mem_geom_pkg::words_per_line; k++) begin : g_slot
                assign lines_out[l][k*mem_geom_pkg::word_width +: mem_geom_pkg::word_width] =
                    words_q[l*mem_geom_pkg::words_per_line + k];
            end
        end
    endgenerate

    // Line read in the same cycle as the request.
    always_comb begin
        exec_beat.valid = is_load;
        exec_beat.line  = lines_out[line_idx];
    end

endmodule

//--- verilog/mem_req_decode.sv
`timescale 1ns/1ns

module mem_req_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  logic                   store,
    input  mem_geom_pkg::addr_t    address,
    input  mem_geom_pkg::word_t    evict_data,
    output mem_req_pkg::mem_req_t  dec_req
);

    mem_req_pkg::req_kind_e next_kind;       // Classified strobe pair.
    mem_req_pkg::req_kind_e kind_q;          // Registered kind.
    mem_geom_pkg::addr_t    addr_q;          // Registered address.
    mem_geom_pkg::word_t    data_q;          // Registered store word.

    // Store when store is high, load otherwise; nothing without req.
    always_comb begin
        case ({req, store})
            2'b11:   next_kind = mem_req_pkg::store;
            2'b10:   next_kind = mem_req_pkg::load;
            default: next_kind = mem_req_pkg::idle;
        endcase
    end

    // Only the kind is control state.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind_q <= mem_req_pkg::idle;
        end else begin
            kind_q <= next_kind;
        end
    end

    // Payload follows the strobe and holds while idle.
    always_ff @(posedge clk) begin
        if (req) begin
            addr_q <= address;
            data_q <= evict_data;
        end
    end

    // Pack into the typed request for the array.
    always_comb begin
        dec_req.kind = kind_q;
        dec_req.addr = addr_q;
        dec_req.data = data_q;
    end

endmodule

//--- verilog/mem_req_pkg.sv
package mem_req_pkg;

    // Kind of request taken on a clock edge.
    typedef enum logic [1:0] {
        idle  = 2'd0,    // No request this cycle.
        store = 2'd1,    // Write one word.
        load  = 2'd2     // Read back a whole line.
    } req_kind_e;

    // Registered request as seen by the word array.
    typedef struct packed {
        req_kind_e           kind;    // What to do.
        mem_geom_pkg::addr_t addr;    // Word address.
        mem_geom_pkg::word_t data;    // Store data, don't care on a load.
    } mem_req_t;

    // One stage of the fill delay line.
    typedef struct packed {
        logic                valid;   // Set for a load in flight.
        mem_geom_pkg::line_t line;    // Line read at load time.
    } fill_beat_t;

endpackage

//--- verilog/mem_geom_pkg.sv
package mem_geom_pkg;

    // Word and line geometry of the backing memory.
    localparam int word_width     = 32;    // One store word.
    localparam int line_width     = 128;   // One fill line.
    localparam int words_per_line = line_width / word_width;

    // Width of an address as it arrives from the cache side.
    localparam int addr_bits = 32;

    // A single stored word.
    typedef logic [word_width-1:0] word_t;

    // A full fill line, word 0 in the lowest bits.
    typedef logic [line_width-1:0] line_t;

    // Word address; bits above the storage index are ignored.
    typedef logic [addr_bits-1:0] addr_t;

endpackage
